// File: Makefile
# Verilator simulation of the masked reduction unit

VERILATOR ?= verilator
TOP       ?= tb_masked_reduce
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal
PASS_TEXT ?= STATUS: PASS

.PHONY: sim clean

# Build, run, and succeed only if the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: compile.f
+incdir+hw
+incdir+tests
hw/mlkem_arith_pkg.sv
hw/mlkem_mask_pkg.sv
hw/share_delay_line.sv
hw/mask_rng.sv
hw/masked_barrett_cond_sub.sv
hw/masked_barrett_reduction.sv
hw/masked_reduce_top.sv
tests/tb_masked_reduce.sv

// File: hw/mask_rng.sv
`include "mlkem_cfg.svh"

module mask_rng (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         seed_load,
    input  logic [`RNG_STATE_WIDTH-1:0]  seed,
    output mlkem_mask_pkg::mask_rnd_t    rnd
);

    import mlkem_mask_pkg::*;

    localparam int SW = `RNG_STATE_WIDTH;
    // Enough steps so every bundle bit is a new feedback bit
    localparam int STEPS = $bits(mask_rnd_t);

    logic [SW-1:0] state;
    logic [SW-1:0] state_next;
    logic          seeded;

    // Fibonacci LFSR, taps 96 94 49 47
    function automatic logic [SW-1:0] lfsr_advance(input logic [SW-1:0] s);
        logic [SW-1:0] r;
        logic          fb;
        r = s;
        for (int i = 0; i < STEPS; i++) begin
            fb = r[SW-1] ^ r[SW-3] ^ r[48] ^ r[46];
            r  = {r[SW-2:0], fb};
        end
        return r;
    endfunction

    assign state_next = lfsr_advance(state);

    // State holds until the host loads a seed
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= '0;
            seeded <= 1'b0;
        end else if (seed_load) begin
            state  <= seed;
            seeded <= 1'b1;
        end else if (seeded) begin
            state <= state_next;
        end
    end

    assign rnd = state[$bits(mask_rnd_t)-1:0];

    // A zero seed would lock the LFSR
    a_state_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        seeded |-> (state != '0));

endmodule

// File: hw/masked_barrett_cond_sub.sv
`include "mlkem_cfg.svh"

module masked_barrett_cond_sub (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          zeroize,
    input  mlkem_arith_pkg::masked_roll_t c_rolled,
    input  mlkem_mask_pkg::mask_rnd_t     rnd,
    output mlkem_arith_pkg::masked_q_t    arith_q
);

    import mlkem_arith_pkg::*;

    localparam int RW = $bits(roll_share_t);
    localparam int QW = `MLKEM_Q_WIDTH;
    localparam logic [QW-1:0] Q = QW'(`MLKEM_Q);

    // Boolean shares of sum bits 13 and 12
    logic [1:0]    top_b0;
    logic [1:0]    top_b1;
    logic [1:0]    top_b0_q;
    logic [1:0]    top_b1_q;
    // Refreshed shares of c >= q
    logic          ge_b0_q;
    logic          ge_b1_q;
    logic [QW-1:0] pick_m1_zero;
    logic [QW-1:0] pick_m1_one;
    masked_q_t     arith_q_next;

    // --------------------------------------------------
    // Stage 1 A2B through a masked ripple carry chain
    // --------------------------------------------------
    // Domain 0 owns share0, domain 1 owns share1
    always_comb begin
        logic k0;
        logic k1;
        logic n0;
        logic n1;
        k0 = 1'b0;
        k1 = 1'b0;
        top_b0 = '0;
        top_b1 = '0;
        for (int i = 0; i < RW; i++) begin
            if (i >= RW - 2) begin
                top_b0[i-(RW-2)] = c_rolled.share0[i] ^ k0;
                top_b1[i-(RW-2)] = c_rolled.share1[i] ^ k1;
            end
            // Generate term masked by rnd_bool0, propagate AND as DOM with rnd_bool1
            n0 = (c_rolled.share0[i] & c_rolled.share1[i] ^ rnd.rnd_bool0[i])
               ^ (c_rolled.share0[i] & k0)
               ^ (c_rolled.share0[i] & k1 ^ rnd.rnd_bool1[i]);
            n1 = rnd.rnd_bool0[i]
               ^ (c_rolled.share1[i] & k0 ^ rnd.rnd_bool1[i])
               ^ (c_rolled.share1[i] & k1);
            k0 = n0;
            k1 = n1;
        end
    end

    // --------------------------------------------------
    // Stage 3 B2A of the bit into shares of q or zero
    // --------------------------------------------------
    // Domain 0 prepares both candidates, domain 1 picks one
    always_comb begin
        pick_m1_zero = (ge_b0_q ? Q : '0) - rnd.rnd_12bit;
        pick_m1_one  = (ge_b0_q ? '0 : Q) - rnd.rnd_12bit;
        arith_q_next.share0 = rnd.rnd_12bit + rnd.rnd_14bit[QW-1:0];
        arith_q_next.share1 = (ge_b1_q ? pick_m1_one : pick_m1_zero)
                            - rnd.rnd_14bit[QW-1:0];
    end

    always_ff @(posedge clk) begin
        if (!rst_n || zeroize) begin
            top_b0_q <= '0;
            top_b1_q <= '0;
            ge_b0_q  <= 1'b0;
            ge_b1_q  <= 1'b0;
            arith_q  <= '0;
        end else begin
            top_b0_q <= top_b0;
            top_b1_q <= top_b1;
            // Stage 2, bit 13 never joins bit 12 so XOR acts as OR
            ge_b0_q  <= top_b0_q[0] ^ top_b0_q[1] ^ rnd.rnd_1bit;
            ge_b1_q  <= top_b1_q[0] ^ top_b1_q[1] ^ rnd.rnd_1bit;
            arith_q  <= arith_q_next;
        end
    end

    a_q_or_zero: assert property (@(posedge clk) disable iff (!rst_n || zeroize)
        (QW'(arith_q.share0 + arith_q.share1) == '0) ||
        (QW'(arith_q.share0 + arith_q.share1) == Q));

endmodule

// File: hw/masked_barrett_reduction.sv
`include "mlkem_cfg.svh"

module masked_barrett_reduction (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          zeroize,
    input  mlkem_arith_pkg::masked_word_t x,
    input  mlkem_mask_pkg::mask_rnd_t     rnd,
    output mlkem_arith_pkg::masked_word_t y
);

    import mlkem_arith_pkg::*;

    localparam int XW = `MASKED_REG_SIZE;
    localparam int CW = $bits(c_share_t);
    localparam int RW = $bits(roll_share_t);
    localparam int QW = `MLKEM_Q_WIDTH;
    // Width of x * mu
    localparam int PW = XW + CW;
    // Barrett constant floor(2^24 / q) = 5039
    localparam int MU = (1 << XW) / `MLKEM_Q;
    // Carry correction of mu split over both shares
    localparam logic [CW-1:0] MU_LO = CW'(MU % 128);
    localparam logic [CW-1:0] MU_HI = CW'(MU - MU % 128);
    // c + ROLLER reaches 2^12 exactly when c >= q
    localparam logic [RW-1:0] ROLLER = RW'((1 << QW) - `MLKEM_Q);

    masked_c_t    t_next;
    masked_c_t    t_q;
    masked_c_t    x_lo_q;
    masked_c_t    c_next;
    masked_c_t    c_q;
    masked_c_t    c_del;
    masked_roll_t c_rolled;
    masked_q_t    arith_q;
    masked_word_t y_next;

    logic [XW:0]   x_sum;
    logic [PW-1:0] prod0;
    logic [PW-1:0] prod1;
    logic [XW:0]   prod_lo_sum;
    logic [RW-1:0] c_sum;
    logic [QW-1:0] y_int0;
    logic [QW-1:0] y_int1;
    logic [QW:0]   y_sum;

    // mu = 2^12 + 2^9 + 2^8 + 2^7 + 2^5 + 2^3 + 2^2 + 2 + 1
    function automatic logic [PW-1:0] mul_mu(input logic [XW-1:0] a);
        logic [PW-1:0] ae;
        ae = PW'(a);
        return (ae << 12) + (ae << 9) + (ae << 8) + (ae << 7)
             + (ae << 5) + (ae << 3) + (ae << 2) + (ae << 1) + ae;
    endfunction

    // q = 2^11 + 2^10 + 2^8 + 1, only the low 13 bits matter
    function automatic logic [CW-1:0] mul_q(input logic [CW-1:0] b);
        return (b << 11) + (b << 10) + (b << 8) + b;
    endfunction

    // --------------------------------------------------
    // Stage 1 masked t = (x * mu) >> 24
    // --------------------------------------------------
    always_comb begin
        x_sum       = {1'b0, x.share0} + {1'b0, x.share1};
        prod0       = mul_mu(x.share0);
        prod1       = mul_mu(x.share1);
        prod_lo_sum = {1'b0, prod0[XW-1:0]} + {1'b0, prod1[XW-1:0]};
        // Remove the 2^24 wrap of the input shares from t
        t_next.share0 = prod0[PW-1:XW] + CW'(prod_lo_sum[XW])
                      - (x_sum[XW] ? MU_LO : '0);
        t_next.share1 = prod1[PW-1:XW] - (x_sum[XW] ? MU_HI : '0);
    end

    // Stage 2 c = x - q*t per share, mod 2^13
    always_comb begin
        c_next.share0 = x_lo_q.share0 - mul_q(t_q.share0);
        c_next.share1 = x_lo_q.share1 - mul_q(t_q.share1);
    end

    // --------------------------------------------------
    // Stage 3 roll c into 14 bits for the comparison
    // --------------------------------------------------
    always_comb begin
        c_sum = {1'b0, c_q.share0} + {1'b0, c_q.share1};
        c_rolled.share0 = {1'b0, c_q.share0} + ROLLER
                        - (c_sum[RW-1] ? RW'(1 << CW) : '0);
        c_rolled.share1 = {1'b0, c_q.share1};
    end

    masked_barrett_cond_sub i_cond_sub (
        .clk      (clk),
        .rst_n    (rst_n),
        .zeroize  (zeroize),
        .c_rolled (c_rolled),
        .rnd      (rnd),
        .arith_q  (arith_q)
    );

    // Keeps c in step with the returned q-or-zero shares
    share_delay_line #(
        .payload_t (masked_c_t),
        .DEPTH     (`COND_SUB_LATENCY)
    ) i_c_delay (
        .clk     (clk),
        .rst_n   (rst_n),
        .zeroize (zeroize),
        .d       (c_q),
        .q       (c_del)
    );

    // Stage 4 y = c - q or c, widened and remasked
    always_comb begin
        y_int0 = c_del.share0[QW-1:0] - arith_q.share0;
        y_int1 = c_del.share1[QW-1:0] - arith_q.share1;
        y_sum  = {1'b0, y_int0} + {1'b0, y_int1};
        y_next.share0 = XW'(y_int0) - rnd.rnd_24bit - (y_sum[QW] ? XW'(1 << QW) : '0);
        y_next.share1 = XW'(y_int1) + rnd.rnd_24bit;
    end

    always_ff @(posedge clk) begin
        if (!rst_n || zeroize) begin
            t_q    <= '0;
            x_lo_q <= '0;
            c_q    <= '0;
            y      <= '0;
        end else begin
            t_q           <= t_next;
            x_lo_q.share0 <= x.share0[CW-1:0];
            x_lo_q.share1 <= x.share1[CW-1:0];
            c_q           <= c_next;
            y             <= y_next;
        end
    end

    // Every stage holds a consistent item, so y is always fully reduced
    a_y_reduced: assert property (@(posedge clk) disable iff (!rst_n)
        !zeroize |=> (XW'(y.share0 + y.share1) < XW'(`MLKEM_Q)));

endmodule

// File: hw/masked_reduce_top.sv
`include "mlkem_cfg.svh"

module masked_reduce_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          zeroize,
    input  logic                          seed_load,
    input  logic [`RNG_STATE_WIDTH-1:0]   seed,
    input  logic                          in_valid,
    input  mlkem_mask_pkg::tag_t          in_tag,
    input  mlkem_arith_pkg::masked_word_t in_word,
    output logic                          out_valid,
    output mlkem_mask_pkg::tag_t          out_tag,
    output mlkem_arith_pkg::masked_word_t out_word
);

    import mlkem_mask_pkg::*;

    mask_rnd_t     rnd;
    tagged_valid_t tv_in;
    tagged_valid_t tv_out;

    mask_rng i_rng (
        .clk       (clk),
        .rst_n     (rst_n),
        .seed_load (seed_load),
        .seed      (seed),
        .rnd       (rnd)
    );

    masked_barrett_reduction i_reduce (
        .clk     (clk),
        .rst_n   (rst_n),
        .zeroize (zeroize),
        .x       (in_word),
        .rnd     (rnd),
        .y       (out_word)
    );

    // Valid and tag ride beside the datapath
    assign tv_in.valid = in_valid;
    assign tv_in.tag   = in_tag;

    share_delay_line #(
        .payload_t (tagged_valid_t),
        .DEPTH     (`BARRETT_LATENCY)
    ) i_tag_delay (
        .clk     (clk),
        .rst_n   (rst_n),
        .zeroize (zeroize),
        .d       (tv_in),
        .q       (tv_out)
    );

    assign out_valid = tv_out.valid;
    assign out_tag   = tv_out.tag;

endmodule

// File: hw/mlkem_arith_pkg.sv
`include "mlkem_cfg.svh"

package mlkem_arith_pkg;

    // Single share widths
    typedef logic [`MASKED_REG_SIZE-1:0] word_share_t;
    typedef logic [`MLKEM_Q_WIDTH:0]     c_share_t;
    typedef logic [`MLKEM_Q_WIDTH+1:0]   roll_share_t;
    typedef logic [`MLKEM_Q_WIDTH-1:0]   q_share_t;

    // Two-share word, secret is share0 + share1 mod 2^24
    typedef struct packed {
        word_share_t share1;
        word_share_t share0;
    } masked_word_t;

    // Intermediate values t and x - q*t, shared mod 2^13
    typedef struct packed {
        c_share_t share1;
        c_share_t share0;
    } masked_c_t;

    // c shifted by 2^12 - q, shared mod 2^14
    typedef struct packed {
        roll_share_t share1;
        roll_share_t share0;
    } masked_roll_t;

    // Shares of either q or zero, mod 2^12
    typedef struct packed {
        q_share_t share1;
        q_share_t share0;
    } masked_q_t;

endpackage

// File: hw/mlkem_cfg.svh
`ifndef MLKEM_CFG_SVH
`define MLKEM_CFG_SVH

// ML-KEM modulus
`define MLKEM_Q 3329

// Width of a fully reduced residue
`define MLKEM_Q_WIDTH 12

// Width of one arithmetic input share
`define MASKED_REG_SIZE 24

// Pipeline depths in clock cycles
`define BARRETT_LATENCY 6
`define COND_SUB_LATENCY 3

// State width of the mask generator LFSR
`define RNG_STATE_WIDTH 96

`endif

// File: hw/mlkem_mask_pkg.sv
`include "mlkem_cfg.svh"

package mlkem_mask_pkg;

    // Fresh randomness consumed by the reduction in one cycle
    typedef struct packed {
        // B2A remask of the q-or-zero shares
        logic [`MLKEM_Q_WIDTH-1:0]   rnd_12bit;
        logic [`MLKEM_Q_WIDTH+1:0]   rnd_14bit;
        // Output remask
        logic [`MASKED_REG_SIZE-1:0] rnd_24bit;
        // Gadget randomness of the masked carry chain
        logic [`MLKEM_Q_WIDTH+1:0]   rnd_bool0;
        logic [`MLKEM_Q_WIDTH+1:0]   rnd_bool1;
        // Refresh of the comparison bit
        logic                        rnd_1bit;
    } mask_rnd_t;

    // Host request tag
    typedef logic [7:0] tag_t;

    // Bookkeeping that travels beside each item
    typedef struct packed {
        logic valid;
        tag_t tag;
    } tagged_valid_t;

endpackage

// File: hw/share_delay_line.sv
module share_delay_line #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 1
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     zeroize,
    input  payload_t d,
    output payload_t q
);

    payload_t stage_q [DEPTH];

    // Plain shift register, wiped as a whole
    always_ff @(posedge clk) begin
        if (!rst_n || zeroize) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            stage_q[0] <= d;
            for (int i = 1; i < DEPTH; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign q = stage_q[DEPTH-1];

endmodule

// File: tests/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Columns are secret, generator seed, expected residue (secret mod q)
typedef struct packed {
    logic [`MASKED_REG_SIZE-1:0] secret;
    logic [`RNG_STATE_WIDTH-1:0] seed;
    logic [`MLKEM_Q_WIDTH-1:0]   residue;
} vector_t;

localparam int NUM_VECTORS = 20;

// Entry whose secret is reduced twice under different seeds
localparam int SAME_SECRET_IDX = 9;

localparam vector_t VECTORS [NUM_VECTORS] = '{
    '{24'd0,        96'h00000000_00000000_00000001, 12'd0},
    '{24'd1,        96'h9e3779b9_7f4a7c15_f39cc060, 12'd1},
    '{24'd3328,     96'h12345678_9abcdef0_0fedcba9, 12'd3328},
    '{24'd3329,     96'hdeadbeef_cafef00d_01234567, 12'd0},
    '{24'd6658,     96'h0badc0de_5eed1234_76543210, 12'd0},
    '{24'd6657,     96'hffffffff_ffffffff_ffffffff, 12'd3328},
    '{24'd6659,     96'h80000000_00000000_00000000, 12'd1},
    '{24'd9987,     96'h13579bdf_2468ace0_11223344, 12'd0},
    '{24'd4096,     96'h55555555_aaaaaaaa_55555555, 12'd767},
    '{24'hABCDEF,   96'h3c3c3c3c_c3c3c3c3_0f0f0f0f, 12'd697},
    '{24'h123456,   96'h6a09e667_bb67ae85_3c6ef372, 12'd1264},
    '{24'hC0FFEE,   96'ha54ff53a_510e527f_9b05688c, 12'd1559},
    '{24'h5A5A5A,   96'h1f83d9ab_5be0cd19_428a2f98, 12'd2408},
    '{24'hDEAD42,   96'h71374491_b5c0fbcf_e9b5dba5, 12'd2339},
    '{24'd1000000,  96'h3956c25b_59f111f1_923f82a4, 12'd1300},
    '{24'h3FFFFF,   96'hab1c5ed5_d807aa98_12835b01, 12'd3092},
    '{24'h800000,   96'h243185be_550c7dc3_72be5d74, 12'd2857},
    '{24'hFFF000,   96'h80deb1fe_9bdc06a7_c19bf174, 12'd1618},
    '{24'd9986,     96'he49b69c1_efbe4786_0fc19dc6, 12'd3328},
    '{24'hFFFFFF,   96'h240ca1cc_2de92c6f_4a7484aa, 12'd2384}
};

// Row names, same order as the table above
string vec_names [NUM_VECTORS] = '{
    "zero", "one", "q_minus_1", "q",
    "two_q", "two_q_minus_1", "two_q_plus_1", "three_q",
    "pow2_12", "rand_abcdef", "rand_123456", "rand_c0ffee",
    "rand_5a5a5a", "rand_dead42", "dec_1000000", "pow2_22_minus_1",
    "pow2_23", "top_fff000", "three_q_minus_1", "all_ones"
};

`endif

// File: tests/tb_masked_reduce.sv
`include "mlkem_cfg.svh"

module tb_masked_reduce;

    import mlkem_arith_pkg::*;
    import mlkem_mask_pkg::*;

    `include "tb_vectors.svh"

    localparam int XW  = `MASKED_REG_SIZE;
    localparam int QW  = `MLKEM_Q_WIDTH;
    localparam int LAT = `BARRETT_LATENCY;
    localparam int WATCHDOG_TIME = (NUM_VECTORS + 20) * 100 * 4;

    logic                        clk;
    logic                        rst_n;
    logic                        zeroize;
    logic                        seed_load;
    logic [`RNG_STATE_WIDTH-1:0] seed;
    logic                        in_valid;
    tag_t                        in_tag;
    masked_word_t                in_word;
    logic                        out_valid;
    tag_t                        out_tag;
    masked_word_t                out_word;

    logic [31:0]  lfsr_state;
    int           err_count;
    int           test_count;
    int           fail_count;
    int           cycle_cnt;
    tag_t         next_tag;
    masked_word_t last_word;

    // Scoreboard of results still in flight
    string          exp_name_q [$];
    tag_t           exp_tag_q  [$];
    logic [QW-1:0]  exp_res_q  [$];
    int             exp_cyc_q  [$];

    always #50 clk = ~clk;

    masked_reduce_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .zeroize   (zeroize),
        .seed_load (seed_load),
        .seed      (seed),
        .in_valid  (in_valid),
        .in_tag    (in_tag),
        .in_word   (in_word),
        .out_valid (out_valid),
        .out_tag   (out_tag),
        .out_word  (out_word)
    );

    // 32-bit Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step for every bit of the share
    task automatic draw_share(output logic [XW-1:0] v);
        for (int i = 0; i < XW; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[XW-2:0], lfsr_state[0]};
        end
    endtask

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic check_word(input string name, input masked_word_t act,
                              input logic [QW-1:0] exp_res);
        logic [XW-1:0] sum;
        sum = act.share0 + act.share1;
        if (sum !== XW'(exp_res)) begin
            $display("[ERROR] %s: residue expected %0d, actual %0d", name, exp_res, sum);
            err_count++;
        end
    endtask

    task automatic check_tag(input string name, input tag_t exp_tag, input tag_t act);
        if (act !== exp_tag) begin
            $display("[ERROR] %s: tag expected %0d, actual %0d", name, exp_tag, act);
            err_count++;
        end
    endtask

    task automatic check_cleared(input string name, input logic act_valid,
                                 input masked_word_t act);
        if (act_valid !== 1'b0 || act !== '0) begin
            $display("[ERROR] %s: expected out_valid 0 and out_word 0, actual %b and %h",
                     name, act_valid, act);
            err_count++;
        end
    endtask

    task automatic report_test(input string name, input bit ok);
        test_count++;
        if (ok) begin
            $display("test %s: ok", name);
        end else begin
            fail_count++;
            $display("test %s: failed", name);
        end
    endtask

    // --------------------------------------------------
    // Drive helpers
    // --------------------------------------------------
    task automatic issue(input string name, input vector_t vec, input bit track);
        masked_word_t w;
        draw_share(w.share0);
        w.share1 = vec.secret - w.share0;
        @(posedge clk);
        in_valid  <= 1'b1;
        in_tag    <= next_tag;
        in_word   <= w;
        seed_load <= 1'b1;
        seed      <= vec.seed;
        if (track) begin
            exp_name_q.push_back(name);
            exp_tag_q.push_back(next_tag);
            exp_res_q.push_back(vec.residue);
            exp_cyc_q.push_back(cycle_cnt);
        end
        next_tag = next_tag + 1'b1;
    endtask

    task automatic idle();
        @(posedge clk);
        in_valid  <= 1'b0;
        seed_load <= 1'b0;
        in_word   <= '0;
    endtask

    task automatic wait_drain(input int max_cycles);
        int n;
        n = 0;
        while (exp_tag_q.size() != 0 && n < max_cycles) begin
            @(posedge clk);
            n++;
        end
        if (exp_tag_q.size() != 0) begin
            $display("Timed out waiting for %0d result(s), the first is %s",
                     exp_tag_q.size(), exp_name_q[0]);
            err_count++;
            exp_name_q.delete();
            exp_tag_q.delete();
            exp_res_q.delete();
            exp_cyc_q.delete();
        end
    endtask

    // Outputs sampled at the falling edge, half a cycle after they settle
    always @(negedge clk) begin
        int errs_before;
        if (out_valid === 1'b1) begin
            last_word = out_word;
            if (exp_tag_q.size() == 0) begin
                $display("out_valid went high with no request in flight, tag %0d", out_tag);
                err_count++;
            end else begin
                errs_before = err_count;
                check_tag(exp_name_q[0], exp_tag_q[0], out_tag);
                check_word(exp_name_q[0], out_word, exp_res_q[0]);
                if (cycle_cnt - exp_cyc_q[0] != LAT) begin
                    $display("[ERROR] %s: latency expected %0d, actual %0d",
                             exp_name_q[0], LAT, cycle_cnt - exp_cyc_q[0]);
                    err_count++;
                end
                report_test(exp_name_q[0], err_count == errs_before);
                void'(exp_name_q.pop_front());
                void'(exp_tag_q.pop_front());
                void'(exp_res_q.pop_front());
                void'(exp_cyc_q.pop_front());
            end
        end
        cycle_cnt = cycle_cnt + 1;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Watchdog expired after %0d time units, run stopped", WATCHDOG_TIME);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        logic [XW-1:0] share_a;
        logic [XW-1:0] share_b;
        logic [31:0]   lfsr_saved;
        int            errs_before;
        clk        = 1'b0;
        rst_n      = 1'b0;
        zeroize    = 1'b0;
        seed_load  = 1'b0;
        seed       = '0;
        in_valid   = 1'b0;
        in_tag     = '0;
        in_word    = '0;
        lfsr_state = 32'h9cee;
        err_count  = 0;
        test_count = 0;
        fail_count = 0;
        cycle_cnt  = 0;
        next_tag   = 8'h10;
        last_word  = '0;

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        errs_before = err_count;
        check_cleared("reset_state", out_valid, out_word);
        check_tag("reset_state", '0, out_tag);
        report_test("reset_state", err_count == errs_before);

        // Whole table back to back, six items in flight
        for (int i = 0; i < NUM_VECTORS; i++) begin
            issue(vec_names[i], VECTORS[i], 1'b1);
        end
        idle();
        wait_drain(LAT + 4);

        // Same secret and same input shares under two seeds
        errs_before = err_count;
        lfsr_saved  = lfsr_state;
        issue("mask_seed_a", VECTORS[SAME_SECRET_IDX], 1'b1);
        idle();
        wait_drain(LAT + 4);
        share_a = last_word.share1;
        lfsr_state = lfsr_saved;
        issue("mask_seed_b", vector_t'{VECTORS[SAME_SECRET_IDX].secret,
                                       VECTORS[SAME_SECRET_IDX + 1].seed,
                                       VECTORS[SAME_SECRET_IDX].residue}, 1'b1);
        idle();
        wait_drain(LAT + 4);
        share_b = last_word.share1;
        if (share_a === share_b) begin
            $display("Second output share did not change with the seed, both %h", share_a);
            err_count++;
        end
        report_test("fresh_masking", err_count == errs_before);

        // --------------------------------------------------
        // Zeroize with four items in flight
        // --------------------------------------------------
        errs_before = err_count;
        for (int i = 10; i < 14; i++) begin
            issue(vec_names[i], VECTORS[i], 1'b0);
        end
        @(posedge clk);
        in_valid  <= 1'b0;
        seed_load <= 1'b0;
        zeroize   <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_cleared("zeroize", out_valid, out_word);
        @(posedge clk);
        zeroize <= 1'b0;
        @(negedge clk);
        check_cleared("zeroize", out_valid, out_word);
        repeat (LAT + 2) @(posedge clk);
        report_test("zeroize", err_count == errs_before);

        for (int i = 15; i < 18; i++) begin
            issue({"post_zeroize_", vec_names[i]}, VECTORS[i], 1'b1);
        end
        idle();
        wait_drain(LAT + 4);

        $display("tests run: %0d, failed: %0d, errors: %0d", test_count, fail_count, err_count);
        if (err_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
